// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // address split: tag | index | offset
    localparam int OFFSET_BITS    = 5;
    localparam int INDEX_BITS     = 3;
    localparam int TAG_BITS       = 24;
    localparam int NUM_LINES      = 8;
    localparam int BEATS_PER_LINE = 4;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef logic [31:0]           addr_t;
    typedef logic [63:0]           word_t;    // also the AXI beat
    typedef logic [7:0]            strb_t;
    typedef logic [255:0]          line_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [1:0]            beat_cnt_t;

    // miss sequencing in the lookup
    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        REPLAY
    } lookup_state_e;

    typedef enum logic [1:0] {
        W_IDLE,
        W_AW,
        W_DATA,
        W_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_AR,
        R_DATA
    } rd_state_e;

endpackage

`default_nettype wire

// ==== line_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one line transfer per request, single credit
interface line_req_if import dcache_pkg::*; ();

    logic  req_valid;
    logic  req_write;      // 1 = write-back, 0 = refill
    addr_t req_addr;       // line aligned
    line_t req_line;
    logic  credit_return;

    modport initiator (
        output req_valid, req_write, req_addr, req_line,
        input  credit_return
    );

    modport target (
        input  req_valid, req_write, req_addr, req_line,
        output credit_return
    );

endinterface

`default_nettype wire

// ==== beat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface beat_if import dcache_pkg::*; ();

    logic  beat_valid;    // one pulse per R handshake
    word_t beat_data;
    logic  beat_last;
    logic  beat_err;

    modport source (output beat_valid, beat_data, beat_last, beat_err);
    modport sink   (input  beat_valid, beat_data, beat_last, beat_err);

endinterface

`default_nettype wire

// ==== dcache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup import dcache_pkg::*; (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 req_valid_i,
    input  wire                 req_write_i,
    input  addr_t               req_addr_i,
    input  word_t               req_wdata_i,
    input  strb_t               req_strb_i,
    output logic                req_ready_o,
    output logic                resp_valid_o,
    output word_t               resp_rdata_o,
    output logic                resp_err_o,
    line_req_if.initiator       line_req,
    input  wire                 fill_valid_i,
    input  line_t               fill_line_i,
    input  wire                 fill_err_i
);

    lookup_state_e state_q;

    // arrays
    tag_t                 tag_q  [NUM_LINES];
    line_t                data_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;

    // held request
    logic  pend_q;
    logic  req_write_q;
    addr_t req_addr_q;
    word_t req_wdata_q;
    strb_t req_strb_q;

    logic  alive_q;
    logic  credit_q;      // the bridge's only transfer credit
    logic  fill_err_q;
    logic  resp_valid_q;
    logic  resp_err_q;
    word_t resp_rdata_q;

    tag_t      req_tag;
    index_t    req_idx;
    beat_cnt_t req_wsel;
    line_t     cur_line;
    word_t     cur_word;
    word_t     new_word;
    logic      hit;
    logic      serve;
    logic      req_fire;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return res;
    endfunction

    assign req_tag  = req_addr_q[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign req_idx  = req_addr_q[OFFSET_BITS +: INDEX_BITS];
    assign req_wsel = req_addr_q[OFFSET_BITS-1 -: $bits(beat_cnt_t)];  // word within line

    assign cur_line = data_q[req_idx];
    assign cur_word = cur_line[req_wsel*$bits(word_t) +: $bits(word_t)];
    assign new_word = req_write_q ? merge_bytes(cur_word, req_wdata_q, req_strb_q) : cur_word;
    assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    // answer on a hit, or on replay after a clean fill
    assign serve = (state_q == IDLE && pend_q && hit) || (state_q == REPLAY && !fill_err_q);

    assign req_ready_o = alive_q && state_q == IDLE && !pend_q && !resp_valid_q;
    assign req_fire    = req_valid_i && req_ready_o;

    assign resp_valid_o = resp_valid_q;
    assign resp_err_o   = resp_err_q;
    assign resp_rdata_o = resp_rdata_q;

    // victim line first, then the refill
    assign line_req.req_valid = credit_q && (state_q == WRITEBACK || state_q == REFILL_REQ);
    assign line_req.req_write = (state_q == WRITEBACK);
    assign line_req.req_addr  = (state_q == WRITEBACK)
                              ? {tag_q[req_idx], req_idx, {OFFSET_BITS{1'b0}}}
                              : {req_tag, req_idx, {OFFSET_BITS{1'b0}}};
    assign line_req.req_line  = cur_line;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q      <= IDLE;
            alive_q      <= 1'b0;
            pend_q       <= 1'b0;
            credit_q     <= 1'b1;
            valid_q      <= '0;
            dirty_q      <= '0;
            fill_err_q   <= 1'b0;
            resp_valid_q <= 1'b0;
            resp_err_q   <= 1'b0;
        end else begin
            alive_q      <= 1'b1;
            resp_valid_q <= serve || state_q == REPLAY;
            if (line_req.req_valid) begin
                credit_q <= 1'b0;
            end else if (line_req.credit_return) begin
                credit_q <= 1'b1;
            end
            if (serve && req_write_q) dirty_q[req_idx] <= 1'b1;

            case (state_q)
                IDLE: begin
                    if (req_fire) begin
                        pend_q <= 1'b1;
                    end else if (serve) begin
                        pend_q     <= 1'b0;
                        resp_err_q <= 1'b0;
                    end else if (pend_q) begin
                        // miss
                        if (valid_q[req_idx] && dirty_q[req_idx]) state_q <= WRITEBACK;
                        else                                      state_q <= REFILL_REQ;
                    end
                end
                WRITEBACK: begin
                    if (credit_q) state_q <= REFILL_REQ;
                end
                REFILL_REQ: begin
                    if (credit_q) state_q <= REFILL_WAIT;
                end
                REFILL_WAIT: begin
                    if (fill_valid_i) begin
                        valid_q[req_idx] <= !fill_err_i;    // bad line stays out
                        dirty_q[req_idx] <= 1'b0;
                        fill_err_q       <= fill_err_i;
                        state_q          <= REPLAY;
                    end
                end
                REPLAY: begin
                    pend_q     <= 1'b0;
                    resp_err_q <= fill_err_q;
                    state_q    <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (req_fire) begin
            req_write_q <= req_write_i;
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
            req_strb_q  <= req_strb_i;
        end
        if (serve) begin
            resp_rdata_q <= new_word;
            if (req_write_q) data_q[req_idx][req_wsel*$bits(word_t) +: $bits(word_t)] <= new_word;
        end else if (state_q == REPLAY) begin
            resp_rdata_q <= '0;    // errored fill
        end
        if (state_q == REFILL_WAIT && fill_valid_i) begin
            data_q[req_idx] <= fill_line_i;
            tag_q[req_idx]  <= req_tag;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_axi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_axi_bridge import dcache_pkg::*; (
    input  wire         clock,
    input  wire         reset,
    line_req_if.target  line_req,
    beat_if.source      beats,

    output logic        axi_aw_valid_o,
    input  wire         axi_aw_ready_i,
    output addr_t       axi_aw_addr_o,

    output logic        axi_w_valid_o,
    input  wire         axi_w_ready_i,
    output word_t       axi_w_data_o,
    output strb_t       axi_w_strb_o,
    output logic        axi_w_last_o,

    input  wire         axi_b_valid_i,
    output logic        axi_b_ready_o,
    input  wire  [1:0]  axi_b_resp_i,    // accepted, not checked

    output logic        axi_ar_valid_o,
    input  wire         axi_ar_ready_i,
    output addr_t       axi_ar_addr_o,

    input  wire         axi_r_valid_i,
    output logic        axi_r_ready_o,
    input  word_t       axi_r_data_i,
    input  wire  [1:0]  axi_r_resp_i,
    input  wire         axi_r_last_i
);

    wr_state_e wr_state_q;
    rd_state_e rd_state_q;
    beat_cnt_t wr_cnt_q;
    addr_t     wr_addr_q;
    addr_t     rd_addr_q;
    line_t     wr_line_q;
    logic      credit_ret_q;
    logic      wr_last;
    logic      b_done;
    logic      r_done;

    assign wr_last = (wr_cnt_q == beat_cnt_t'(BEATS_PER_LINE - 1));
    assign b_done  = axi_b_valid_i && axi_b_ready_o;
    assign r_done  = axi_r_valid_i && axi_r_ready_o && axi_r_last_i;

    // write side
    assign axi_aw_valid_o = (wr_state_q == W_AW);
    assign axi_aw_addr_o  = wr_addr_q;
    assign axi_w_valid_o  = (wr_state_q == W_DATA);
    assign axi_w_data_o   = wr_line_q[wr_cnt_q*$bits(word_t) +: $bits(word_t)];
    assign axi_w_strb_o   = '1;    // full line
    assign axi_w_last_o   = wr_last;
    assign axi_b_ready_o  = (wr_state_q == W_RESP);

    // read side
    assign axi_ar_valid_o = (rd_state_q == R_AR);
    assign axi_ar_addr_o  = rd_addr_q;
    assign axi_r_ready_o  = (rd_state_q == R_DATA);

    assign beats.beat_valid = axi_r_valid_i && axi_r_ready_o;
    assign beats.beat_data  = axi_r_data_i;
    assign beats.beat_last  = axi_r_last_i;
    assign beats.beat_err   = (axi_r_resp_i != AXI_RESP_OKAY);

    assign line_req.credit_return = credit_ret_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state_q <= W_IDLE;
            wr_cnt_q   <= '0;
        end else begin
            case (wr_state_q)
                W_IDLE: begin
                    if (line_req.req_valid && line_req.req_write) begin
                        wr_state_q <= W_AW;
                        wr_cnt_q   <= '0;
                    end
                end
                W_AW: begin
                    if (axi_aw_ready_i) wr_state_q <= W_DATA;
                end
                W_DATA: begin
                    if (axi_w_ready_i) begin
                        if (wr_last) wr_state_q <= W_RESP;
                        else         wr_cnt_q   <= wr_cnt_q + 1'b1;
                    end
                end
                W_RESP: begin
                    if (axi_b_valid_i) wr_state_q <= W_IDLE;
                end
                default: wr_state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_state_q <= R_IDLE;
        end else begin
            case (rd_state_q)
                R_IDLE: begin
                    if (line_req.req_valid && !line_req.req_write) rd_state_q <= R_AR;
                end
                R_AR: begin
                    if (axi_ar_ready_i) rd_state_q <= R_DATA;
                end
                R_DATA: begin
                    if (r_done) rd_state_q <= R_IDLE;
                end
                default: rd_state_q <= R_IDLE;
            endcase
        end
    end

    // one transfer done -> credit back a cycle later
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) credit_ret_q <= 1'b0;
        else        credit_ret_q <= b_done || r_done;
    end

    always_ff @(posedge clock) begin
        if (wr_state_q == W_IDLE && line_req.req_valid && line_req.req_write) begin
            wr_addr_q <= line_req.req_addr;
            wr_line_q <= line_req.req_line;
        end
        if (rd_state_q == R_IDLE && line_req.req_valid && !line_req.req_write) begin
            rd_addr_q <= line_req.req_addr;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_refill import dcache_pkg::*; (
    input  wire    clock,
    input  wire    reset,
    beat_if.sink   beats,
    output logic   fill_valid_o,
    output line_t  fill_line_o,
    output logic   fill_err_o
);

    beat_cnt_t cnt_q;
    logic      err_q;      // sticky over the burst
    logic      fill_valid_q;
    line_t     line_q;

    assign fill_valid_o = fill_valid_q;
    assign fill_line_o  = line_q;
    assign fill_err_o   = err_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cnt_q        <= '0;
            err_q        <= 1'b0;
            fill_valid_q <= 1'b0;
        end else begin
            fill_valid_q <= beats.beat_valid && beats.beat_last;
            if (fill_valid_q) begin
                // line handed over, start clean
                cnt_q <= '0;
                err_q <= 1'b0;
            end else if (beats.beat_valid) begin
                cnt_q <= cnt_q + 1'b1;
                err_q <= err_q | beats.beat_err;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (beats.beat_valid) line_q[cnt_q*$bits(word_t) +: $bits(word_t)] <= beats.beat_data;
    end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  wire         clock,
    input  wire         reset,

    // core load/store port
    input  wire         req_valid_i,
    input  wire         req_write_i,
    input  addr_t       req_addr_i,
    input  word_t       req_wdata_i,
    input  strb_t       req_strb_i,
    output logic        req_ready_o,
    output logic        resp_valid_o,
    output word_t       resp_rdata_o,
    output logic        resp_err_o,

    // AXI master
    output logic        axi_aw_valid_o,
    input  wire         axi_aw_ready_i,
    output addr_t       axi_aw_addr_o,
    output logic        axi_w_valid_o,
    input  wire         axi_w_ready_i,
    output word_t       axi_w_data_o,
    output strb_t       axi_w_strb_o,
    output logic        axi_w_last_o,
    input  wire         axi_b_valid_i,
    output logic        axi_b_ready_o,
    input  wire  [1:0]  axi_b_resp_i,
    output logic        axi_ar_valid_o,
    input  wire         axi_ar_ready_i,
    output addr_t       axi_ar_addr_o,
    input  wire         axi_r_valid_i,
    output logic        axi_r_ready_o,
    input  word_t       axi_r_data_i,
    input  wire  [1:0]  axi_r_resp_i,
    input  wire         axi_r_last_i
);

    line_req_if line_req ();
    beat_if     beats ();

    logic  fill_valid;
    line_t fill_line;
    logic  fill_err;

    dcache_lookup lookup_i (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .resp_err_o   (resp_err_o),
        .line_req     (line_req.initiator),
        .fill_valid_i (fill_valid),
        .fill_line_i  (fill_line),
        .fill_err_i   (fill_err)
    );

    dcache_axi_bridge bridge_i (
        .clock          (clock),
        .reset          (reset),
        .line_req       (line_req.target),
        .beats          (beats.source),
        .axi_aw_valid_o (axi_aw_valid_o),
        .axi_aw_ready_i (axi_aw_ready_i),
        .axi_aw_addr_o  (axi_aw_addr_o),
        .axi_w_valid_o  (axi_w_valid_o),
        .axi_w_ready_i  (axi_w_ready_i),
        .axi_w_data_o   (axi_w_data_o),
        .axi_w_strb_o   (axi_w_strb_o),
        .axi_w_last_o   (axi_w_last_o),
        .axi_b_valid_i  (axi_b_valid_i),
        .axi_b_ready_o  (axi_b_ready_o),
        .axi_b_resp_i   (axi_b_resp_i),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_resp_i   (axi_r_resp_i),
        .axi_r_last_i   (axi_r_last_i)
    );

    dcache_refill refill_i (
        .clock        (clock),
        .reset        (reset),
        .beats        (beats.sink),
        .fill_valid_o (fill_valid),
        .fill_line_o  (fill_line),
        .fill_err_o   (fill_err)
    );

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// 4 KB AXI slave memory with one burst per channel at a time
module tb_axi_mem import dcache_pkg::*; (
    input  wire         clock,
    input  wire         stall_en_i,
    input  wire addr_t  err_line_i,    // reads of this line answer SLVERR
    input  wire         aw_valid_i,
    output logic        aw_ready_o,
    input  wire addr_t  aw_addr_i,
    input  wire         w_valid_i,
    output logic        w_ready_o,
    input  wire word_t  w_data_i,
    input  wire         w_last_i,
    output logic        b_valid_o,
    input  wire         b_ready_i,
    output logic [1:0]  b_resp_o,
    input  wire         ar_valid_i,
    output logic        ar_ready_o,
    input  wire addr_t  ar_addr_i,
    output logic        r_valid_o,
    input  wire         r_ready_i,
    output word_t       r_data_o,
    output logic [1:0]  r_resp_o,
    output logic        r_last_o
);

    localparam logic [1:0] SLVERR = 2'b10;

    word_t       mem [512];
    addr_t       wr_addr;
    addr_t       rd_addr;
    int          rd_left;      // beats still to send
    logic        b_pend;
    logic        aw_hs;
    logic        w_hs;
    logic        b_hs;
    logic        ar_hs;
    logic        r_hs;
    int          aw_wait;
    int          w_wait;
    int          b_wait;
    int          ar_wait;
    int          r_wait;
    logic [31:0] lfsr_q;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 0..3 idle cycles with one LFSR step per bit
    function automatic int draw_wait();
        int n;
        n = 0;
        if (stall_en_i) begin
            for (int b = 0; b < 2; b++) begin
                lfsr_q = lfsr_next(lfsr_q);
                n      = (n << 1) | int'(lfsr_q[0]);
            end
        end
        return n;
    endfunction

    // raise sig once want has lasted wait_n cycles and drop it after each handshake
    task automatic pace(inout logic sig, inout int wait_n, input logic want, input logic hs);
        if (hs) begin
            sig    = 1'b0;
            wait_n = draw_wait();
        end else if (want && !sig) begin
            if (wait_n == 0) sig = 1'b1;
            else             wait_n--;
        end
    endtask

    initial begin
        lfsr_q     = 32'h7935;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_resp_o   = AXI_RESP_OKAY;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = AXI_RESP_OKAY;
        r_last_o   = 1'b0;
        b_pend     = 1'b0;
        rd_left    = 0;
        wr_addr    = '0;
        rd_addr    = '0;
        {aw_hs, w_hs, b_hs, ar_hs, r_hs} = '0;
        {aw_wait, w_wait, b_wait, ar_wait, r_wait} = '0;
    end

    // handshakes and memory updates at the rising edge
    always @(posedge clock) begin
        aw_hs <= aw_valid_i && aw_ready_o;
        w_hs  <= w_valid_i && w_ready_o;
        b_hs  <= b_valid_o && b_ready_i;
        ar_hs <= ar_valid_i && ar_ready_o;
        r_hs  <= r_valid_o && r_ready_i;
        if (aw_valid_i && aw_ready_o) wr_addr <= aw_addr_i;
        if (w_valid_i && w_ready_o) begin
            mem[wr_addr[11:3]] <= w_data_i;    // strobes are all ones
            wr_addr            <= wr_addr + 8;
            if (w_last_i) b_pend <= 1'b1;
        end
        if (b_valid_o && b_ready_i) b_pend <= 1'b0;
        if (ar_valid_i && ar_ready_o) begin
            rd_addr <= ar_addr_i;
            rd_left <= BEATS_PER_LINE;
        end
        if (r_valid_o && r_ready_i) begin
            rd_addr <= rd_addr + 8;
            rd_left <= rd_left - 1;
        end
    end

    // outputs change on the falling edge
    always @(negedge clock) begin
        pace(aw_ready_o, aw_wait, aw_valid_i, aw_hs);
        pace(w_ready_o, w_wait, w_valid_i, w_hs);
        pace(b_valid_o, b_wait, b_pend, b_hs);
        pace(ar_ready_o, ar_wait, ar_valid_i, ar_hs);
        pace(r_valid_o, r_wait, rd_left != 0, r_hs);
        r_data_o = mem[rd_addr[11:3]];
        r_last_o = (rd_left == 1);
        r_resp_o = ({rd_addr[31:5], 5'b0} == err_line_i) ? SLVERR : AXI_RESP_OKAY;
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int    MAX_ACCESSES   = 40;     // 23 issued over all tests
    localparam int    ACCESS_BOUND   = 100;    // miss with write-back under stalls
    localparam int    TIMEOUT_CYCLES = MAX_ACCESSES * ACCESS_BOUND;
    localparam word_t FILL_K         = 64'h9e37_79b9_7f4a_7c15;
    localparam addr_t ERR_LINE       = 32'h0000_0f00;

    logic       clock;
    logic       reset;
    logic       req_valid;
    logic       req_write;
    addr_t      req_addr;
    word_t      req_wdata;
    strb_t      req_strb;
    logic       req_ready;
    logic       resp_valid;
    word_t      resp_rdata;
    logic       resp_err;
    logic       aw_valid;
    logic       aw_ready;
    addr_t      aw_addr;
    logic       w_valid;
    logic       w_ready;
    word_t      w_data;
    strb_t      w_strb;
    logic       w_last;
    logic       b_valid;
    logic       b_ready;
    logic [1:0] b_resp;
    logic       ar_valid;
    logic       ar_ready;
    addr_t      ar_addr;
    logic       r_valid;
    logic       r_ready;
    word_t      r_data;
    logic [1:0] r_resp;
    logic       r_last;
    logic       stall_en;

    word_t sb_mem [512];    // memory as the core sees it
    addr_t ar_log [$];
    addr_t aw_log [$];
    word_t w_log [$];
    strb_t w_strb_log [$];
    logic  w_last_log [$];
    int    cycle;
    int    first_ar_cycle;
    int    last_w_cycle;
    int    errors;
    int    tests_run;
    int    tests_failed;

    dcache_top dut_i (
        .clock (clock), .reset (reset),
        .req_valid_i (req_valid), .req_write_i (req_write), .req_addr_i (req_addr),
        .req_wdata_i (req_wdata), .req_strb_i (req_strb), .req_ready_o (req_ready),
        .resp_valid_o (resp_valid), .resp_rdata_o (resp_rdata), .resp_err_o (resp_err),
        .axi_aw_valid_o (aw_valid), .axi_aw_ready_i (aw_ready), .axi_aw_addr_o (aw_addr),
        .axi_w_valid_o (w_valid), .axi_w_ready_i (w_ready), .axi_w_data_o (w_data),
        .axi_w_strb_o (w_strb), .axi_w_last_o (w_last),
        .axi_b_valid_i (b_valid), .axi_b_ready_o (b_ready), .axi_b_resp_i (b_resp),
        .axi_ar_valid_o (ar_valid), .axi_ar_ready_i (ar_ready), .axi_ar_addr_o (ar_addr),
        .axi_r_valid_i (r_valid), .axi_r_ready_o (r_ready), .axi_r_data_i (r_data),
        .axi_r_resp_i (r_resp), .axi_r_last_i (r_last)
    );

    tb_axi_mem mem_i (
        .clock (clock), .stall_en_i (stall_en), .err_line_i (ERR_LINE),
        .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_addr_i (aw_addr),
        .w_valid_i (w_valid), .w_ready_o (w_ready), .w_data_i (w_data), .w_last_i (w_last),
        .b_valid_o (b_valid), .b_ready_i (b_ready), .b_resp_o (b_resp),
        .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
        .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data),
        .r_resp_o (r_resp), .r_last_o (r_last)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // bus monitor sampling handshakes at the rising edge
    always @(posedge clock) begin
        cycle = cycle + 1;
        if (ar_valid && ar_ready) begin
            if (ar_log.size() == 0) first_ar_cycle = cycle;
            ar_log.push_back(ar_addr);
        end
        if (aw_valid && aw_ready) aw_log.push_back(aw_addr);
        if (w_valid && w_ready) begin
            w_log.push_back(w_data);
            w_strb_log.push_back(w_strb);
            w_last_log.push_back(w_last);
            last_w_cycle = cycle;
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // byte address times a constant
    function automatic word_t fill_word(int widx);
        return word_t'(widx * 8) * FILL_K;
    endfunction

    function automatic word_t apply_strobes(word_t old_w, word_t new_w, strb_t s);
        word_t res;
        for (int b = 0; b < 8; b++) begin
            res[8*b +: 8] = s[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("wrong %s: %0d seen, %0d expected", what, got, exp);
            errors++;
        end
    endtask

    task automatic clear_logs();
        ar_log.delete();
        aw_log.delete();
        w_log.delete();
        w_strb_log.delete();
        w_last_log.delete();
        first_ar_cycle = 0;
        last_w_cycle   = 0;
    endtask

    // one core access where lat counts edges from acceptance to the response
    task automatic access(input logic wr, input addr_t a, input word_t d, input strb_t s,
                          output word_t rdata, output logic err, output int lat);
        logic busy;
        busy = 1'b0;
        @(negedge clock);
        while (!req_ready) @(negedge clock);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = a;
        req_wdata = d;
        req_strb  = s;
        @(negedge clock);
        req_valid = 1'b0;
        lat       = 0;
        if (req_ready) busy = 1'b1;
        while (!resp_valid) begin
            @(negedge clock);
            lat++;
            if (req_ready) busy = 1'b1;
        end
        if (busy) begin
            $display("req_ready_o was high while a request was outstanding");
            errors++;
        end
        rdata = resp_rdata;
        err   = resp_err;
    endtask

    task automatic do_load(input addr_t a, output int lat);
        word_t rdata;
        logic  err;
        access(1'b0, a, '0, '0, rdata, err, lat);
        check_word("resp_rdata_o", rdata, sb_mem[a[11:3]]);
        check_err("resp_err_o", err, 1'b0);
    endtask

    task automatic do_store(input addr_t a, input word_t d, input strb_t s);
        word_t rdata;
        logic  err;
        int    lat;
        access(1'b1, a, d, s, rdata, err, lat);
        sb_mem[a[11:3]] = apply_strobes(sb_mem[a[11:3]], d, s);
        check_err("resp_err_o", err, 1'b0);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_load_miss();
        int e0;
        int lat;
        e0 = errors;
        clear_logs();
        do_load(32'h48, lat);
        check_count("number of AR bursts", ar_log.size(), 1);
        if (ar_log.size() > 0) check_addr("axi_ar_addr_o", ar_log[0], 32'h40);
        do_load(32'h50, lat);    // same line and now resident
        check_count("number of AR bursts", ar_log.size(), 1);
        end_test("load_miss", e0);
    endtask

    task automatic test_store_hit();
        int e0;
        int lat;
        e0 = errors;
        clear_logs();
        do_store(32'h48, 64'h1122_3344_5566_7788, 8'b0101_1010);
        do_load(32'h48, lat);
        check_count("latency of a load hit", lat, 1);
        check_count("number of AR bursts", ar_log.size(), 0);
        end_test("store_hit", e0);
    endtask

    task automatic test_dirty_evict();
        int e0;
        int lat;
        e0 = errors;
        clear_logs();
        do_load(32'h148, lat);    // index 2 again with the dirty victim 0x40
        check_count("number of AW bursts", aw_log.size(), 1);
        check_count("number of W beats", w_log.size(), 4);
        check_count("number of AR bursts", ar_log.size(), 1);
        if (aw_log.size() > 0) check_addr("axi_aw_addr_o", aw_log[0], 32'h40);
        if (ar_log.size() > 0) check_addr("axi_ar_addr_o", ar_log[0], 32'h140);
        for (int i = 0; i < 4 && i < w_log.size(); i++) begin
            check_word("axi_w_data_o", w_log[i], sb_mem[(32'h40 >> 3) + i]);
            check_strb("axi_w_strb_o", w_strb_log[i], 8'hff);
            check_last("axi_w_last_o", w_last_log[i], i == 3);
        end
        if (first_ar_cycle <= last_w_cycle) begin
            $display("refill AR was issued before the write-back burst ended");
            errors++;
        end
        end_test("dirty_evict", e0);
    endtask

    task automatic test_stalled_mix();
        int    e0;
        int    lat;
        addr_t a;
        e0 = errors;
        @(posedge clock);
        stall_en = 1'b1;
        for (int i = 0; i < 16; i++) begin
            // tags 0..5 over all indices and clear of the error line
            a = {20'h0, 4'(i * 5 % 6), 3'(i * 3 % 8), 2'(i % 4), 3'b000};
            if (i % 3 == 0) do_store(a, {32'(i), 32'h0bad_c0de}, strb_t'(8'hff << (i % 5)));
            else            do_load(a, lat);
        end
        @(posedge clock);
        stall_en = 1'b0;
        end_test("stalled_mix", e0);
    endtask

    task automatic test_read_error();
        int    e0;
        int    lat;
        word_t rdata;
        logic  err;
        e0 = errors;
        clear_logs();
        access(1'b0, ERR_LINE + 8, '0, '0, rdata, err, lat);
        check_err("resp_err_o", err, 1'b1);
        access(1'b0, ERR_LINE + 8, '0, '0, rdata, err, lat);
        check_err("resp_err_o", err, 1'b1);
        check_count("number of AR bursts", ar_log.size(), 2);    // line never installed
        foreach (ar_log[i]) check_addr("axi_ar_addr_o", ar_log[i], ERR_LINE);
        end_test("read_error", e0);
    endtask

    initial begin
        reset        = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_strb     = '0;
        stall_en     = 1'b0;
        cycle        = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_logs();
        for (int i = 0; i < 512; i++) begin
            sb_mem[i]    = fill_word(i);
            mem_i.mem[i] = fill_word(i);
        end
        repeat (4) @(negedge clock);
        reset = 1'b1;
        test_load_miss();
        test_store_hit();
        test_dirty_evict();
        test_stalled_mix();
        test_read_error();
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
dcache_pkg.sv
line_req_if.sv
beat_if.sv
dcache_lookup.sv
dcache_axi_bridge.sv
dcache_refill.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - line_req_if.sv
  - beat_if.sv
  - dcache_lookup.sv
  - dcache_axi_bridge.sv
  - dcache_refill.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_axi_mem.sv
      - tb_dcache.sv
